// ==== verilog/loader_pkg.sv ====
/*
 * CPS-1.5 loader shared definitions
 * Bus widths, download targets, SDRAM bank codes and the
 * default byte-address starts of the ROM regions
 */
package loader_pkg;

    // Download byte address and SDRAM word address
    localparam int IOCTL_AW = 25;
    localparam int PROG_AW  = 22;

    // Programming and EEPROM words
    localparam int WORD_W   = 16;
    localparam int EE_AW    = 7;

    // Target of a byte leaving the router
    typedef enum logic [1:0] {
        TGT_NONE   = 2'd0,
        TGT_ROM    = 2'd1,
        TGT_EEPROM = 2'd2
    } load_tgt_e;

    // SDRAM bank of a programming write
    typedef enum logic [1:0] {
        BANK_MAIN  = 2'd0,
        BANK_SOUND = 2'd1,
        BANK_GFX   = 2'd2,
        BANK_PCM   = 2'd3
    } prog_bank_e;

    // Region starts in the download stream, main CPU ROM begins at zero
    localparam logic [IOCTL_AW-1:0] DEF_SND_START = 25'h0010_0000;
    localparam logic [IOCTL_AW-1:0] DEF_GFX_START = 25'h0020_0000;
    localparam logic [IOCTL_AW-1:0] DEF_PCM_START = 25'h0040_0000;

endpackage

// ==== verilog/ioctl_router.sv ====
/*
 * Download router
 * Registers each ioctl byte, tags it for the ROM or EEPROM path
 * and stretches the download busy flag while bytes drain
 */
module ioctl_router (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               downloading,
    input  logic [loader_pkg::IOCTL_AW-1:0]    ioctl_addr,
    input  logic [7:0]                         ioctl_data,
    input  logic                               ioctl_wr,
    input  logic                               ioctl_ram,
    output loader_pkg::load_tgt_e              rt_tgt,
    output logic [loader_pkg::IOCTL_AW-1:0]    rt_addr,
    output logic [7:0]                         rt_data,
    output logic                               dwnld_busy
);

    // Two bytes can still be in the formatters when downloading drops
    localparam logic [1:0] DRAIN_CYCLES = 2'd2;

    logic [1:0] drain_cnt;

    // Target tag, idle when no strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rt_tgt <= loader_pkg::TGT_NONE;
        end else if (ioctl_wr) begin
            rt_tgt <= ioctl_ram ? loader_pkg::TGT_EEPROM : loader_pkg::TGT_ROM;
        end else begin
            rt_tgt <= loader_pkg::TGT_NONE;
        end
    end

    // Address and byte follow the strobe
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            rt_addr <= ioctl_addr;
            rt_data <= ioctl_data;
        end
    end

    // Reloaded while downloading, counts down afterwards
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drain_cnt <= 2'd0;
        end else if (downloading) begin
            drain_cnt <= DRAIN_CYCLES;
        end else if (drain_cnt != 2'd0) begin
            drain_cnt <= drain_cnt - 2'd1;
        end
    end

    assign dwnld_busy = downloading | (drain_cnt != 2'd0);

endmodule

// ==== verilog/rom_prog_formatter.sv ====
/*
 * ROM programming formatter
 * Maps a routed ROM byte to an SDRAM bank by address region and
 * issues a byte-masked word write relative to that region
 */
module rom_prog_formatter #(
    parameter logic [loader_pkg::IOCTL_AW-1:0] SND_START = loader_pkg::DEF_SND_START,
    parameter logic [loader_pkg::IOCTL_AW-1:0] GFX_START = loader_pkg::DEF_GFX_START,
    parameter logic [loader_pkg::IOCTL_AW-1:0] PCM_START = loader_pkg::DEF_PCM_START
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  loader_pkg::load_tgt_e              rt_tgt,
    input  logic [loader_pkg::IOCTL_AW-1:0]    rt_addr,
    input  logic [7:0]                         rt_data,
    output logic [loader_pkg::PROG_AW-1:0]     prog_addr,
    output logic [loader_pkg::WORD_W-1:0]      prog_data,
    output logic [1:0]                         prog_mask,
    output loader_pkg::prog_bank_e             prog_ba,
    output logic                               prog_we
);

    loader_pkg::prog_bank_e             bank;
    logic [loader_pkg::IOCTL_AW-1:0]    region_start;
    logic [loader_pkg::IOCTL_AW-1:0]    region_off;

    // Highest region whose start is not above the address
    always_comb begin
        if (rt_addr >= PCM_START) begin
            bank         = loader_pkg::BANK_PCM;
            region_start = PCM_START;
        end else if (rt_addr >= GFX_START) begin
            bank         = loader_pkg::BANK_GFX;
            region_start = GFX_START;
        end else if (rt_addr >= SND_START) begin
            bank         = loader_pkg::BANK_SOUND;
            region_start = SND_START;
        end else begin
            bank         = loader_pkg::BANK_MAIN;
            region_start = '0;
        end
    end

    assign region_off = rt_addr - region_start;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
        end else begin
            prog_we <= (rt_tgt == loader_pkg::TGT_ROM);
        end
    end

    always_ff @(posedge clk) begin
        if (rt_tgt == loader_pkg::TGT_ROM) begin
            // Byte offset to word address
            prog_addr <= region_off[loader_pkg::PROG_AW:1];
            prog_data <= {rt_data, rt_data};
            // Active low, odd bytes go to the upper lane
            prog_mask <= rt_addr[0] ? 2'b01 : 2'b10;
            prog_ba   <= bank;
        end
    end

endmodule

// ==== verilog/eeprom_word_packer.sv ====
/*
 * EEPROM word packer
 * Holds the even byte of a settings pair and writes the full
 * word when the odd byte arrives
 */
module eeprom_word_packer (
    input  logic                               clk,
    input  logic                               arst_n,
    input  loader_pkg::load_tgt_e              rt_tgt,
    input  logic [loader_pkg::IOCTL_AW-1:0]    rt_addr,
    input  logic [7:0]                         rt_data,
    output logic                               ee_we,
    output logic [loader_pkg::EE_AW-1:0]       ee_waddr,
    output logic [loader_pkg::WORD_W-1:0]      ee_wdata
);

    logic       ee_byte;
    logic       hi_byte;
    logic [7:0] lo_hold;

    assign ee_byte = (rt_tgt == loader_pkg::TGT_EEPROM);
    assign hi_byte = rt_addr[0];

    // One write per odd byte
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ee_we <= 1'b0;
        end else begin
            ee_we <= ee_byte & hi_byte;
        end
    end

    // Even byte waits here for its partner
    always_ff @(posedge clk) begin
        if (ee_byte && !hi_byte) begin
            lo_hold <= rt_data;
        end
    end

    always_ff @(posedge clk) begin
        if (ee_byte && hi_byte) begin
            ee_waddr <= rt_addr[loader_pkg::EE_AW:1];
            ee_wdata <= {rt_data, lo_hold};
        end
    end

endmodule

// ==== verilog/eeprom_array.sv ====
/*
 * EEPROM settings store
 * 128 x 16 memory with a word write port from the packer and a
 * registered byte readback port on the download address
 */
module eeprom_array (
    input  logic                               clk,
    input  logic                               ee_we,
    input  logic [loader_pkg::EE_AW-1:0]       ee_waddr,
    input  logic [loader_pkg::WORD_W-1:0]      ee_wdata,
    input  logic [loader_pkg::IOCTL_AW-1:0]    ioctl_addr,
    output logic [7:0]                         ioctl_data_out
);

    localparam int DEPTH = 1 << loader_pkg::EE_AW;

    logic [loader_pkg::WORD_W-1:0] mem [DEPTH];
    logic [loader_pkg::WORD_W-1:0] rd_word;
    logic                          rd_hi;

    // Word write from the packer
    always_ff @(posedge clk) begin
        if (ee_we) begin
            mem[ee_waddr] <= ee_wdata;
        end
    end

    // Registered read, byte select follows the address
    always_ff @(posedge clk) begin
        rd_word <= mem[ioctl_addr[loader_pkg::EE_AW:1]];
        rd_hi   <= ioctl_addr[0];
    end

    assign ioctl_data_out = rd_hi ? rd_word[15:8] : rd_word[7:0];

endmodule

// ==== verilog/cps_loader_top.sv ====
/*
 * CPS-1.5 loading and save-data path
 * Routes the ioctl download stream to SDRAM programming writes
 * or to the EEPROM settings store, and reads settings back
 */
module cps_loader_top #(
    parameter logic [loader_pkg::IOCTL_AW-1:0] SND_START = loader_pkg::DEF_SND_START,
    parameter logic [loader_pkg::IOCTL_AW-1:0] GFX_START = loader_pkg::DEF_GFX_START,
    parameter logic [loader_pkg::IOCTL_AW-1:0] PCM_START = loader_pkg::DEF_PCM_START
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               downloading,
    output logic                               dwnld_busy,
    // Download stream
    input  logic [loader_pkg::IOCTL_AW-1:0]    ioctl_addr,
    input  logic [7:0]                         ioctl_data,
    input  logic                               ioctl_wr,
    input  logic                               ioctl_ram,
    output logic [7:0]                         ioctl_data_out,
    // SDRAM programming
    output logic [loader_pkg::PROG_AW-1:0]     prog_addr,
    output logic [loader_pkg::WORD_W-1:0]      prog_data,
    output logic [1:0]                         prog_mask,
    output loader_pkg::prog_bank_e             prog_ba,
    output logic                               prog_we
);

    // Router to formatters
    loader_pkg::load_tgt_e              rt_tgt;
    logic [loader_pkg::IOCTL_AW-1:0]    rt_addr;
    logic [7:0]                         rt_data;

    // Packer to settings store
    logic                               ee_we;
    logic [loader_pkg::EE_AW-1:0]       ee_waddr;
    logic [loader_pkg::WORD_W-1:0]      ee_wdata;

    ioctl_router u_router (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_ram   ( ioctl_ram   ),
        .rt_tgt      ( rt_tgt      ),
        .rt_addr     ( rt_addr     ),
        .rt_data     ( rt_data     ),
        .dwnld_busy  ( dwnld_busy  )
    );

    rom_prog_formatter #(
        .SND_START ( SND_START ),
        .GFX_START ( GFX_START ),
        .PCM_START ( PCM_START )
    ) u_rom_fmt (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .rt_tgt    ( rt_tgt    ),
        .rt_addr   ( rt_addr   ),
        .rt_data   ( rt_data   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_mask ( prog_mask ),
        .prog_ba   ( prog_ba   ),
        .prog_we   ( prog_we   )
    );

    eeprom_word_packer u_ee_pack (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .rt_tgt   ( rt_tgt   ),
        .rt_addr  ( rt_addr  ),
        .rt_data  ( rt_data  ),
        .ee_we    ( ee_we    ),
        .ee_waddr ( ee_waddr ),
        .ee_wdata ( ee_wdata )
    );

    // Readback uses the live download address
    eeprom_array u_ee_array (
        .clk            ( clk            ),
        .ee_we          ( ee_we          ),
        .ee_waddr       ( ee_waddr       ),
        .ee_wdata       ( ee_wdata       ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_data_out ( ioctl_data_out )
    );

endmodule

// ==== sim/tb_clkgen.sv ====
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset released shortly
 * after a fixed number of rising edges
 */
module tb_clkgen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #(PERIOD / 10) arst_n = 1'b1;
    end

endmodule

// ==== sim/tb_cps_loader.sv ====
/*
 * Testbench for the CPS-1.5 loading and save-data path
 * Drives ROM and EEPROM download bytes, models the expected SDRAM
 * programming writes and the settings store, and checks readback
 * and the download busy flag
 */
module tb_cps_loader;

    localparam int CLK_PERIOD     = 100;
    localparam int RST_CYCLES     = 8;
    localparam int DRIVE_DLY      = 10;
    localparam int N_ROM_WRITES   = 48;
    localparam int N_EE_PAIRS     = 16;
    localparam int STIM_CYCLES    = RST_CYCLES + 2 * N_ROM_WRITES + 7 * N_EE_PAIRS + 48;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

    localparam logic [loader_pkg::IOCTL_AW-1:0] SND_START = loader_pkg::DEF_SND_START;
    localparam logic [loader_pkg::IOCTL_AW-1:0] GFX_START = loader_pkg::DEF_GFX_START;
    localparam logic [loader_pkg::IOCTL_AW-1:0] PCM_START = loader_pkg::DEF_PCM_START;

    typedef struct packed {
        logic [31:0] due;
        logic [21:0] addr;
        logic [15:0] data;
        logic [1:0]  mask;
        logic [1:0]  bank;
    } prog_exp_t;

    typedef struct packed {
        logic [31:0] due;
        logic [24:0] addr;
        logic [7:0]  data;
    } read_exp_t;

    logic                               clk;
    logic                               arst_n;
    logic                               downloading;
    logic [loader_pkg::IOCTL_AW-1:0]    ioctl_addr;
    logic [7:0]                         ioctl_data;
    logic                               ioctl_wr;
    logic                               ioctl_ram;
    logic                               dwnld_busy;
    logic [7:0]                         ioctl_data_out;
    logic [loader_pkg::PROG_AW-1:0]     prog_addr;
    logic [loader_pkg::WORD_W-1:0]      prog_data;
    logic [1:0]                         prog_mask;
    loader_pkg::prog_bank_e             prog_ba;
    logic                               prog_we;

    // Reference model state
    prog_exp_t   prog_q[$];
    read_exp_t   rd_q[$];
    prog_exp_t   prog_now;
    read_exp_t   rd_now;
    logic [15:0] shadow [128];
    logic [7:0]  lo_model;
    logic [6:0]  ee_words[$];
    logic        exp_busy;
    logic        fall_seen = 1'b0;
    int          fall_cycle = 0;

    int          cycle = 0;
    int          mismatches = 0;
    int          failures = 0;
    int          seed = 32'hf71c;
    logic [31:0] rnd;

    tb_clkgen #(
        .PERIOD     ( CLK_PERIOD ),
        .RST_CYCLES ( RST_CYCLES )
    ) u_clkgen (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    cps_loader_top #(
        .SND_START ( SND_START ),
        .GFX_START ( GFX_START ),
        .PCM_START ( PCM_START )
    ) UUT (
        .clk            ( clk            ),
        .arst_n         ( arst_n         ),
        .downloading    ( downloading    ),
        .dwnld_busy     ( dwnld_busy     ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_data     ( ioctl_data     ),
        .ioctl_wr       ( ioctl_wr       ),
        .ioctl_ram      ( ioctl_ram      ),
        .ioctl_data_out ( ioctl_data_out ),
        .prog_addr      ( prog_addr      ),
        .prog_data      ( prog_data      ),
        .prog_mask      ( prog_mask      ),
        .prog_ba        ( prog_ba        ),
        .prog_we        ( prog_we        )
    );

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatches++;
        $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cycle);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error: %s (cycle %0d)", what, cycle);
    endtask

    // Bank and word offset from the region map
    function automatic prog_exp_t rom_expect(input logic [24:0] addr, input logic [7:0] data,
                                             input logic [31:0] due);
        prog_exp_t   e;
        logic [24:0] base;
        logic [24:0] off;
        if (addr >= PCM_START) begin
            e.bank = loader_pkg::BANK_PCM;
            base   = PCM_START;
        end else if (addr >= GFX_START) begin
            e.bank = loader_pkg::BANK_GFX;
            base   = GFX_START;
        end else if (addr >= SND_START) begin
            e.bank = loader_pkg::BANK_SOUND;
            base   = SND_START;
        end else begin
            e.bank = loader_pkg::BANK_MAIN;
            base   = 25'h0;
        end
        off    = addr - base;
        e.due  = due;
        e.addr = off[22:1];
        e.data = {data, data};
        e.mask = addr[0] ? 2'b01 : 2'b10;
        return e;
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle_cycle;
        next_cycle();
        ioctl_wr = 1'b0;
    endtask

    task automatic drive_rom(input logic [24:0] addr, input logic [7:0] data);
        next_cycle();
        ioctl_wr   = 1'b1;
        ioctl_ram  = 1'b0;
        ioctl_addr = addr;
        ioctl_data = data;
        prog_q.push_back(rom_expect(addr, data, cycle + 2));
    endtask

    task automatic drive_eeprom(input logic [24:0] addr, input logic [7:0] data);
        next_cycle();
        ioctl_wr   = 1'b1;
        ioctl_ram  = 1'b1;
        ioctl_addr = addr;
        ioctl_data = data;
        if (addr[0]) begin
            shadow[addr[7:1]] = {data, lo_model};
        end else begin
            lo_model = data;
        end
    endtask

    // Byte select follows address bit 0
    task automatic read_back(input logic [24:0] addr);
        read_exp_t r;
        next_cycle();
        ioctl_wr   = 1'b0;
        ioctl_ram  = 1'b0;
        ioctl_addr = addr;
        r.due  = cycle + 1;
        r.addr = addr;
        r.data = addr[0] ? shadow[addr[7:1]][15:8] : shadow[addr[7:1]][7:0];
        rd_q.push_back(r);
    endtask

    // Busy may not drop while the download is running
    busy_during_download: assert property (
        @(posedge clk) disable iff (!arst_n) downloading |-> dwnld_busy
    ) else report_failure("dwnld_busy low while downloading is high");

    // Mid-cycle checks against the model
    always @(negedge clk) begin
        if (arst_n) begin
            if (prog_q.size() > 0 && prog_q[0].due == cycle) begin
                prog_now = prog_q.pop_front();
                assert (prog_we) else report_failure("prog_we pulse missing for a ROM write");
                assert (prog_addr == prog_now.addr)
                    else report_mismatch("prog_addr", 32'(prog_addr), 32'(prog_now.addr));
                assert (prog_data == prog_now.data)
                    else report_mismatch("prog_data", 32'(prog_data), 32'(prog_now.data));
                assert (prog_mask == prog_now.mask)
                    else report_mismatch("prog_mask", 32'(prog_mask), 32'(prog_now.mask));
                assert (prog_ba == prog_now.bank)
                    else report_mismatch("prog_ba", 32'(prog_ba), 32'(prog_now.bank));
            end else begin
                assert (!prog_we) else report_failure("prog_we pulsed with no ROM write due");
            end
            // High while downloading and for two cycles after the fall
            exp_busy = downloading || (fall_seen && (cycle - fall_cycle < 2));
            assert (dwnld_busy == exp_busy)
                else report_mismatch("dwnld_busy", 32'(dwnld_busy), 32'(exp_busy));
            if (rd_q.size() > 0 && rd_q[0].due == cycle) begin
                rd_now = rd_q.pop_front();
                assert (ioctl_data_out == rd_now.data)
                    else report_mismatch($sformatf("ioctl_data_out[%h]", rd_now.addr),
                                         32'(ioctl_data_out), 32'(rd_now.data));
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("error: watchdog expired after %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = 8'h00;
        ioctl_wr    = 1'b0;
        ioctl_ram   = 1'b0;
        lo_model    = 8'h00;
        @(posedge arst_n);
        repeat (4) idle_cycle();
        assert (!prog_we && !dwnld_busy) else report_failure("outputs active after reset");

        next_cycle();
        downloading = 1'b1;
        // Region edges, back to back
        drive_rom(25'h0, 8'h11);
        drive_rom(SND_START - 25'd1, 8'h22);
        drive_rom(SND_START, 8'h33);
        drive_rom(GFX_START - 25'd1, 8'h44);
        drive_rom(GFX_START, 8'h55);
        drive_rom(PCM_START - 25'd1, 8'h66);
        drive_rom(PCM_START, 8'h77);
        drive_rom(PCM_START + 25'd3, 8'h88);
        for (int i = 0; i < N_ROM_WRITES; i++) begin
            rnd = $random(seed);
            drive_rom({2'b00, rnd[22:0]}, rnd[30:23]);
            if (rnd[31]) idle_cycle();
        end

        // Settings pairs at random word addresses
        for (int i = 0; i < N_EE_PAIRS; i++) begin
            rnd = $random(seed);
            drive_eeprom({17'h0, rnd[6:0], 1'b0}, rnd[15:8]);
            drive_eeprom({17'h0, rnd[6:0], 1'b1}, rnd[23:16]);
            ee_words.push_back(rnd[6:0]);
        end
        repeat (4) idle_cycle();
        foreach (ee_words[i]) begin
            read_back({17'h0, ee_words[i], 1'b0});
            read_back({17'h0, ee_words[i], 1'b1});
        end

        // ROM bytes aliasing the settings addresses
        foreach (ee_words[i]) begin
            rnd = $random(seed);
            drive_rom({rnd[24:8], ee_words[i], rnd[0]}, rnd[7:0]);
        end
        repeat (4) idle_cycle();
        foreach (ee_words[i]) begin
            read_back({17'h0, ee_words[i], 1'b1});
            read_back({17'h0, ee_words[i], 1'b0});
        end

        next_cycle();
        downloading = 1'b0;
        fall_cycle  = cycle;
        fall_seen   = 1'b1;
        repeat (6) idle_cycle();
        next_cycle();
        downloading = 1'b1;
        repeat (3) idle_cycle();
        downloading = 1'b0;
        fall_cycle  = cycle;
        repeat (6) idle_cycle();

        if (prog_q.size() != 0) report_failure("ROM writes left without a prog_we pulse");
        if (rd_q.size() != 0) report_failure("readback checks left unserved");
        $display("checks done: mismatches %0d, other errors %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/loader_pkg.sv
verilog/ioctl_router.sv
verilog/rom_prog_formatter.sv
verilog/eeprom_word_packer.sv
verilog/eeprom_array.sv
verilog/cps_loader_top.sv
sim/tb_clkgen.sv
sim/tb_cps_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cps_loader \
    -Mdir obj_dir \
    -f src.f

out=$(./obj_dir/Vtb_cps_loader)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi
